//--- src/radio_ctrl_pkg.sv
// Shared register map, widths and bundles for the radio control and timekeeping block.
// Imported by every stage and by the top level.
package radio_ctrl_pkg;

   //////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////

   typedef logic [7:0]  set_addr_t;   // Settings bus address
   typedef logic [31:0] set_data_t;   // Settings bus data
   typedef logic [2:0]  set_offs_t;   // Offset inside a register block
   typedef logic [63:0] vita_time_t;  // VITA tick count
   typedef logic [7:0]  led_t;
   typedef logic [31:0] rb_word_t;    // Readback word
   typedef logic [3:0]  rb_sel_t;     // Readback index

   //////////////////////////////////////////////////
   // Settings bus register map
   //////////////////////////////////////////////////

   localparam set_addr_t SR_MISC       = 8'd0;
   localparam set_addr_t SR_TIME64     = 8'd10;
   localparam set_addr_t MISC_NUM_REGS = 8'd7;
   localparam set_addr_t TIME_NUM_REGS = 8'd3;

   // Misc block offsets with offset 5 left unused
   localparam set_offs_t MISC_CLOCK   = 3'd0;
   localparam set_offs_t MISC_SERDES  = 3'd1;
   localparam set_offs_t MISC_ADC     = 3'd2;
   localparam set_offs_t MISC_LED_SW  = 3'd3;
   localparam set_offs_t MISC_PHY     = 3'd4;
   localparam set_offs_t MISC_LED_SRC = 3'd6;

   // Timer block offsets
   localparam set_offs_t TIME_HI   = 3'd0;
   localparam set_offs_t TIME_LO   = 3'd1;  // Commits the load
   localparam set_offs_t TIME_MODE = 3'd2;  // Bit 0 set means load at next PPS

   // 1 = LED driven by hardware, 0 = by software
   localparam led_t LED_SRC_RESET = 8'b0001_1110;

   // Bumped when the register interface changes (major, minor)
   localparam rb_word_t COMPAT_NUM = {16'd8, 16'd2};

   // Readback indices
   localparam rb_sel_t RB_TIME_HI = 4'd10;
   localparam rb_sel_t RB_TIME_LO = 4'd11;
   localparam rb_sel_t RB_COMPAT  = 4'd12;
   localparam rb_sel_t RB_STATUS  = 4'd13;
   localparam rb_sel_t RB_PPS_HI  = 4'd14;
   localparam rb_sel_t RB_PPS_LO  = 4'd15;

   //////////////////////////////////////////////////
   // Bundles
   //////////////////////////////////////////////////

   typedef struct packed {
      logic      misc_stb;
      logic      time_stb;
      set_offs_t offs;
      set_data_t data;
   } set_req_t;

   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic link_up;
      logic button;
   } hw_status_t;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } ctrl_outs_t;

   typedef struct packed {
      vita_time_t vita_time;
      vita_time_t vita_time_pps;
      logic       good_sync;
   } time_stat_t;

   typedef enum logic {
      TIME_RUN,
      TIME_ARMED
   } timer_mode_e;

endpackage

//--- src/set_capture.sv
// Input stage of the settings bus. Registers each write and
// decodes whether it hits the misc or the timer register block.
`timescale 1ns/1ns

module set_capture (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   output radio_ctrl_pkg::set_req_t  set_req_o
);
   import radio_ctrl_pkg::*;

   set_addr_t misc_rel;
   set_addr_t time_rel;
   logic      in_misc;
   logic      in_time;
   logic      misc_stb_q;
   logic      time_stb_q;
   set_offs_t offs_q;
   set_data_t data_q;

   // Below-base addresses wrap to large values and fail the compare
   assign misc_rel = set_addr_i - SR_MISC;
   assign time_rel = set_addr_i - SR_TIME64;
   assign in_misc  = misc_rel < MISC_NUM_REGS;
   assign in_time  = time_rel < TIME_NUM_REGS;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         misc_stb_q <= 1'b0;
         time_stb_q <= 1'b0;
      end else begin
         misc_stb_q <= set_stb_i & in_misc;
         time_stb_q <= set_stb_i & in_time;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (set_stb_i) begin
         offs_q <= in_time ? time_rel[2:0] : misc_rel[2:0];
         data_q <= set_data_i;
      end
   end

   assign set_req_o = '{misc_stb: misc_stb_q, time_stb: time_stb_q,
                        offs: offs_q, data: data_q};

   // Block windows must never overlap
   a_one_block: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(set_req_o.misc_stb && set_req_o.time_stb));

endmodule

//--- src/misc_ctrl_regs.sv
// Miscellaneous control registers of the misc block plus the LED source mux.
// Written from the captured settings bus, outputs go straight to the board.
`timescale 1ns/1ns

module misc_ctrl_regs (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  radio_ctrl_pkg::set_req_t   set_req_i,
   input  radio_ctrl_pkg::hw_status_t hw_status_i,
   input  logic                       good_sync_i,
   output radio_ctrl_pkg::ctrl_outs_t ctrl_outs_o,
   output radio_ctrl_pkg::led_t       leds_o
);
   import radio_ctrl_pkg::*;

   logic [4:0] clock_q;      // clock_ready, clk_en, clk_sel
   logic [3:0] serdes_q;     // enable, prbsen, loopen, rx_en
   logic [3:0] adc_q;        // oe_a, on_a, oe_b, on_b
   logic       phy_reset_q;  // Active high in the register
   led_t       led_sw_q;
   led_t       led_src_q;
   led_t       led_hw;

   //////////////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= LED_SRC_RESET;
      end else if (set_req_i.misc_stb) begin
         case (set_req_i.offs)
            MISC_CLOCK:   clock_q     <= set_req_i.data[4:0];
            MISC_SERDES:  serdes_q    <= set_req_i.data[3:0];
            MISC_ADC:     adc_q       <= set_req_i.data[3:0];
            MISC_LED_SW:  led_sw_q    <= set_req_i.data[7:0];
            MISC_PHY:     phy_reset_q <= set_req_i.data[0];
            MISC_LED_SRC: led_src_q   <= set_req_i.data[7:0];
            default: begin
               // Offset 5 held the old bootloader flag, nothing lives there now
            end
         endcase
      end
   end

   assign ctrl_outs_o = '{
      clock_ready: clock_q[4],
      clk_en:      clock_q[3:2],
      clk_sel:     clock_q[1:0],
      ser_enable:  serdes_q[3],
      ser_prbsen:  serdes_q[2],
      ser_loopen:  serdes_q[1],
      ser_rx_en:   serdes_q[0],
      adc_oe_a:    adc_q[3],
      adc_on_a:    adc_q[2],
      adc_oe_b:    adc_q[1],
      adc_on_b:    adc_q[0],
      phy_reset_n: ~phy_reset_q
   };

   //////////////////////////////////////////////////
   // LED mux
   //////////////////////////////////////////////////

   // Link LED only lights once time is locked to PPS
   assign led_hw = {3'b000,
                    hw_status_i.run_tx,
                    hw_status_i.run_rx,
                    hw_status_i.clk_status,
                    hw_status_i.link_up & good_sync_i,
                    1'b0};

   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   // PHY must come out of reset released
   a_phy_released: assert property (@(posedge dsp_clk)
      por_rst |=> ctrl_outs_o.phy_reset_n);

endmodule

//--- src/vita_timer.sv
// 64-bit VITA tick counter. Loaded from the timer block either at once or at
// the next PPS edge, and snapshots the running time on every PPS edge.
`timescale 1ns/1ns

module vita_timer (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  radio_ctrl_pkg::set_req_t   set_req_i,
   input  logic                       pps_i,
   output radio_ctrl_pkg::time_stat_t time_stat_o
);
   import radio_ctrl_pkg::*;

   timer_mode_e state_q;
   set_data_t   time_hi_q;    // Staged high word
   logic        pps_mode_q;   // Last TIME_MODE bit 0
   vita_time_t  arm_time_q;
   vita_time_t  time_q;
   vita_time_t  pps_time_q;
   logic        good_sync_q;
   logic [2:0]  pps_sync_q;   // Two sync flops plus edge history
   logic        pps_edge;
   logic        lo_write;
   logic        load_now;
   logic        load_pps;
   vita_time_t  new_time;

   assign lo_write = set_req_i.time_stb && (set_req_i.offs == TIME_LO);
   assign new_time = {time_hi_q, set_req_i.data};
   assign load_now = lo_write && !pps_mode_q;
   assign pps_edge = pps_sync_q[1] & ~pps_sync_q[2];
   assign load_pps = pps_edge && (state_q == TIME_ARMED);

   //////////////////////////////////////////////////
   // Settings and PPS synchronizer
   //////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_mode_q <= 1'b0;
         pps_sync_q <= '0;
      end else begin
         pps_sync_q <= {pps_sync_q[1:0], pps_i};
         if (set_req_i.time_stb && (set_req_i.offs == TIME_MODE))
            pps_mode_q <= set_req_i.data[0];
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (set_req_i.time_stb && (set_req_i.offs == TIME_HI))
         time_hi_q <= set_req_i.data;
      if (lo_write && pps_mode_q)
         arm_time_q <= new_time;  // Held until the PPS edge
   end

   //////////////////////////////////////////////////
   // Arm FSM and counter
   //////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q     <= TIME_RUN;
         good_sync_q <= 1'b0;
      end else if (lo_write && pps_mode_q) begin
         state_q     <= TIME_ARMED;
         good_sync_q <= 1'b0;     // Cleared until the new PPS lands
      end else if (load_pps) begin
         state_q     <= TIME_RUN;
         good_sync_q <= 1'b1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         time_q <= '0;
      else if (load_now)
         time_q <= new_time;
      else if (load_pps)
         time_q <= arm_time_q;
      else
         time_q <= time_q + 64'd1;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         pps_time_q <= '0;
      else if (load_pps)
         pps_time_q <= arm_time_q;  // Same value the counter takes
      else if (pps_edge)
         pps_time_q <= time_q;
   end

   assign time_stat_o = '{vita_time: time_q, vita_time_pps: pps_time_q,
                          good_sync: good_sync_q};

   // Free running between loads
   a_time_inc: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(load_now || load_pps) |=> time_q == vita_time_t'($past(time_q) + 64'd1));

endmodule

//--- src/status_readback.sv
// Registered readback of status words selected by index. Reading the time
// high word latches the low word so the two halves belong together.
`timescale 1ns/1ns

module status_readback (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  radio_ctrl_pkg::rb_sel_t    rb_sel_i,
   input  radio_ctrl_pkg::time_stat_t time_stat_i,
   input  radio_ctrl_pkg::hw_status_t hw_status_i,
   output radio_ctrl_pkg::rb_word_t   rb_data_o
);
   import radio_ctrl_pkg::*;

   rb_word_t time_lo_snap_q;
   rb_word_t status_word;
   rb_word_t rb_next;

   // Button 13, clock 11, link 10, sync 0
   assign status_word = {18'b0,
                         hw_status_i.button,
                         1'b0,
                         hw_status_i.clk_status,
                         hw_status_i.link_up,
                         9'b0,
                         time_stat_i.good_sync};

   //////////////////////////////////////////////////
   // Word select
   //////////////////////////////////////////////////

   always_comb begin
      case (rb_sel_i)
         RB_TIME_HI: rb_next = time_stat_i.vita_time[63:32];
         RB_TIME_LO: rb_next = time_lo_snap_q;
         RB_COMPAT:  rb_next = COMPAT_NUM;
         RB_STATUS:  rb_next = status_word;
         RB_PPS_HI:  rb_next = time_stat_i.vita_time_pps[63:32];
         RB_PPS_LO:  rb_next = time_stat_i.vita_time_pps[31:0];
         default:    rb_next = '0;  // Buffer pool, GPIO and spare slots
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o      <= '0;
         time_lo_snap_q <= '0;
      end else begin
         rb_data_o <= rb_next;
         if (rb_sel_i == RB_TIME_HI)
            time_lo_snap_q <= time_stat_i.vita_time[31:0];  // Same tick as high
      end
   end

endmodule

//--- src/radio_ctrl_top.sv
// Control register and timekeeping block of the radio in the DSP clock domain.
// Settings writes come in on a strobe bus, status is read back by index.
`timescale 1ns/1ns

module radio_ctrl_top (
   input  logic                       dsp_clk,
   input  logic                       por_rst,

   // Settings bus
   input  logic                       set_stb_i,
   input  radio_ctrl_pkg::set_addr_t  set_addr_i,
   input  radio_ctrl_pkg::set_data_t  set_data_i,

   // Board status and timing
   input  logic                       pps_i,
   input  radio_ctrl_pkg::hw_status_t hw_status_i,

   // Readback
   input  radio_ctrl_pkg::rb_sel_t    rb_sel_i,

   // Board controls
   output radio_ctrl_pkg::ctrl_outs_t ctrl_outs_o,
   output radio_ctrl_pkg::led_t       leds_o,
   output radio_ctrl_pkg::rb_word_t   rb_data_o
);
   import radio_ctrl_pkg::*;

   set_req_t   set_req;    // Captured write, shared by both register blocks
   time_stat_t time_stat;

   //////////////////////////////////////////////////
   // Settings capture
   //////////////////////////////////////////////////

   set_capture u_set_capture (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .set_req_o  (set_req)
   );

   //////////////////////////////////////////////////
   // Control registers and LEDs
   //////////////////////////////////////////////////

   misc_ctrl_regs u_misc_ctrl_regs (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_req_i   (set_req),
      .hw_status_i (hw_status_i),
      .good_sync_i (time_stat.good_sync),  // Gates the link LED
      .ctrl_outs_o (ctrl_outs_o),
      .leds_o      (leds_o)
   );

   //////////////////////////////////////////////////
   // VITA time
   //////////////////////////////////////////////////

   vita_timer u_vita_timer (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_req_i   (set_req),
      .pps_i       (pps_i),
      .time_stat_o (time_stat)
   );

   //////////////////////////////////////////////////
   // Status readback
   //////////////////////////////////////////////////

   status_readback u_status_readback (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .rb_sel_i    (rb_sel_i),
      .time_stat_i (time_stat),
      .hw_status_i (hw_status_i),
      .rb_data_o   (rb_data_o)
   );

endmodule

//--- verif/tb_radio_ctrl_ref.svh
// Expected register state and reference functions for the radio control testbench.
// Included inside the testbench module after the package import.
`ifndef TB_RADIO_CTRL_REF_SVH
`define TB_RADIO_CTRL_REF_SVH

localparam rb_word_t EXP_COMPAT = {16'd8, 16'd2};  // Major 8, minor 2

logic [4:0] m_clock;
logic [3:0] m_serdes;
logic [3:0] m_adc;
logic       m_phy_rst;
led_t       m_led_sw;
led_t       m_led_src;
logic       m_pps_mode;   // Last TIME_MODE bit 0
logic       m_good_sync;

task automatic reset_model();
   m_clock     = '0;
   m_serdes    = '0;
   m_adc       = '0;
   m_phy_rst   = 1'b0;
   m_led_sw    = '0;
   m_led_src   = 8'b0001_1110;  // Hardware owns LEDs 1 to 4
   m_pps_mode  = 1'b0;
   m_good_sync = 1'b0;
endtask

// Misc block 0..6 without 5, timer block 10..12
task automatic apply_write(input set_addr_t addr, input set_data_t data);
   if (addr < 8'd7) begin
      case (addr[2:0])
         3'd0: m_clock   = data[4:0];
         3'd1: m_serdes  = data[3:0];
         3'd2: m_adc     = data[3:0];
         3'd3: m_led_sw  = data[7:0];
         3'd4: m_phy_rst = data[0];
         3'd6: m_led_src = data[7:0];
      endcase
   end else if (addr == 8'd12) begin
      m_pps_mode = data[0];
   end else if (addr == 8'd11 && m_pps_mode) begin
      m_good_sync = 1'b0;  // Arming drops sync until the next PPS
   end
endtask

function automatic ctrl_outs_t exp_ctrl_outs(input logic [4:0] clock, input logic [3:0] serdes,
                                             input logic [3:0] adc, input logic phy_rst);
   ctrl_outs_t c;
   c.clock_ready = clock[4];
   c.clk_en      = clock[3:2];
   c.clk_sel     = clock[1:0];
   c.ser_enable  = serdes[3];
   c.ser_prbsen  = serdes[2];
   c.ser_loopen  = serdes[1];
   c.ser_rx_en   = serdes[0];
   c.adc_oe_a    = adc[3];
   c.adc_on_a    = adc[2];
   c.adc_oe_b    = adc[1];
   c.adc_on_b    = adc[0];
   c.phy_reset_n = !phy_rst;
   return c;
endfunction

function automatic led_t exp_leds(input led_t sw, input led_t src, input hw_status_t hw,
                                  input logic sync);
   led_t hw_bits;
   led_t leds;
   int   i;
   hw_bits    = '0;
   hw_bits[4] = hw.run_tx;
   hw_bits[3] = hw.run_rx;
   hw_bits[2] = hw.clk_status;
   hw_bits[1] = hw.link_up && sync;
   for (i = 0; i < 8; i++)
      leds[i] = src[i] ? hw_bits[i] : sw[i];
   return leds;
endfunction

function automatic rb_word_t exp_status_word(input hw_status_t hw, input logic sync);
   rb_word_t word;
   word     = '0;
   word[13] = hw.button;
   word[11] = hw.clk_status;
   word[10] = hw.link_up;
   word[0]  = sync;
   return word;
endfunction

`endif

//--- verif/tb_radio_ctrl.sv
// Testbench for the radio control block. Drives settings writes, hardware status and PPS,
// and checks outputs and readback against the reference model. Top module is tb_radio_ctrl.
`timescale 1ns/1ns

module tb_radio_ctrl;
   import radio_ctrl_pkg::*;

   localparam int SYNC_TIMEOUT = 40;  // Status polls allowed after PPS

   logic       dsp_clk;
   logic       por_rst;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       pps_i;
   hw_status_t hw_status_i;
   rb_sel_t    rb_sel_i;
   ctrl_outs_t ctrl_outs_o;
   led_t       leds_o;
   rb_word_t   rb_data_o;

   integer seed      = 32'hc194_f0f9;
   int     err_cnt   = 0;
   int     check_cnt = 0;
   logic   cmp_en    = 1'b0;  // Continuous output compare active

   `include "tb_radio_ctrl_ref.svh"

   radio_ctrl_top u_radio_ctrl_top (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic hw_status_t rand_hw();
      logic [31:0] r;
      r = $random(seed);
      return r[4:0];
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      check_cnt++;
      assert (got === want) else begin
         err_cnt++;
         $display("error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      check_cnt++;
      assert (cond) else begin
         err_cnt++;
         $display("%0t ns: %s", $time, what);
      end
   endtask

   // Entered and left 2 ns after a rising edge
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(posedge dsp_clk);
      #2;
      set_stb_i = 1'b0;
      @(posedge dsp_clk);
      #2;
      apply_write(addr, data);  // Register stage has taken it
   endtask

   task automatic read_word(input rb_sel_t sel, output rb_word_t data);
      rb_sel_i = sel;
      @(posedge dsp_clk);
      #2;
      data = rb_data_o;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge dsp_clk);
         #2;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      $display("%0t ns: test %-18s %s (%0d errors)", $time, name,
               (err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
   endtask

   // Board outputs against the model at every falling edge
   always @(negedge dsp_clk) begin
      if (cmp_en) begin
         check_value("ctrl_outs_o", ctrl_outs_o,
                     exp_ctrl_outs(m_clock, m_serdes, m_adc, m_phy_rst));
         check_value("leds_o", leds_o, exp_leds(m_led_sw, m_led_src, hw_status_i, m_good_sync));
      end
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      rb_word_t    rd;
      rb_word_t    hi;
      vita_time_t  v;
      vita_time_t  w;
      logic [31:0] r;
      int          errs;
      int          polls;
      int          k;
      logic        seen;
      por_rst     = 1'b1;
      set_stb_i   = 1'b0;
      set_addr_i  = '0;
      set_data_i  = '0;
      pps_i       = 1'b0;
      hw_status_i = '0;
      rb_sel_i    = '0;
      reset_model();
      repeat (3) @(posedge dsp_clk);
      #2;
      por_rst = 1'b0;
      cmp_en  = 1'b1;

      errs = err_cnt;
      hw_status_i = rand_hw();
      idle_cycles(2);
      check_value("ctrl_outs_o.phy_reset_n", ctrl_outs_o.phy_reset_n, 1'b1);
      read_word(RB_COMPAT, rd);
      check_value("rb_data_o", rd, EXP_COMPAT);
      for (k = 0; k < 10; k++) begin
         read_word(k[3:0], rd);
         check_value("rb_data_o", rd, 32'd0);  // Unmapped index
      end
      end_test("reset state", errs);

      errs = err_cnt;
      repeat (24) begin
         r = rand_word() % 6;
         write_setting(SR_MISC + ((r == 5) ? 8'd6 : r[7:0]), rand_word());
      end
      write_setting(SR_MISC + 8'd5, rand_word());
      for (k = 7; k < 10; k++)
         write_setting(k[7:0], rand_word());
      repeat (4) begin
         r = rand_word() % 243;
         write_setting(8'd13 + r[7:0], rand_word());  // Above the timer block
      end
      idle_cycles(2);
      end_test("control registers", errs);

      errs = err_cnt;
      repeat (16) begin
         write_setting(SR_MISC + MISC_LED_SW, rand_word());
         write_setting(SR_MISC + MISC_LED_SRC, rand_word());
         hw_status_i = rand_hw();
         idle_cycles(1);
         check_value("leds_o", leds_o, exp_leds(m_led_sw, m_led_src, hw_status_i, m_good_sync));
      end
      end_test("led mux", errs);

      errs = err_cnt;
      r = rand_word() & 32'h7fff_ffff;  // Keeps V + 20 clear of wrap
      v = {r, rand_word()};
      write_setting(SR_TIME64 + TIME_MODE, 32'd0);
      write_setting(SR_TIME64 + TIME_HI, v[63:32]);
      write_setting(SR_TIME64 + TIME_LO, v[31:0]);
      idle_cycles(3);
      read_word(RB_TIME_HI, hi);
      read_word(RB_TIME_LO, rd);
      check_true(({hi, rd} >= v + 2) && ({hi, rd} <= v + 20),
                 $sformatf("time readback 0x%0h outside V+2..V+20 for V = 0x%0h", {hi, rd}, v));
      end_test("immediate load", errs);

      errs = err_cnt;
      r = rand_word() | 32'h8000_0000;  // Far ahead of the running time
      w = {r, rand_word()};
      write_setting(SR_TIME64 + TIME_MODE, 32'd1);
      write_setting(SR_TIME64 + TIME_HI, w[63:32]);
      write_setting(SR_TIME64 + TIME_LO, w[31:0]);
      idle_cycles(4);
      read_word(RB_TIME_HI, hi);
      read_word(RB_TIME_LO, rd);
      check_true({hi, rd} < w, "time took the armed value before any PPS edge");
      read_word(RB_STATUS, rd);
      check_value("good_sync", rd[0], 1'b0);
      cmp_en = 1'b0;  // Sync lands a variable number of cycles after PPS
      pps_i  = 1'b1;
      seen   = 1'b0;
      polls  = 0;
      while (!seen && polls < SYNC_TIMEOUT) begin
         read_word(RB_STATUS, rd);
         polls++;
         if (polls == 4)
            pps_i = 1'b0;
         seen = rd[0];
      end
      pps_i = 1'b0;
      if (!seen) begin
         err_cnt++;
         $display("%0t ns: good_sync never rose after the PPS pulse", $time);
      end
      m_good_sync = 1'b1;
      cmp_en      = 1'b1;
      read_word(RB_PPS_HI, hi);
      read_word(RB_PPS_LO, rd);
      check_value("vita_time_pps", {hi, rd}, w);
      hw_status_i.link_up = 1'b1;
      write_setting(SR_MISC + MISC_LED_SRC, 32'h0000_0002);  // Link LED from hardware
      check_value("leds_o", leds_o, exp_leds(m_led_sw, m_led_src, hw_status_i, m_good_sync));
      read_word(RB_STATUS, rd);
      check_value("rb_data_o", rd, exp_status_word(hw_status_i, m_good_sync));
      end_test("pps armed load", errs);

      errs = err_cnt;
      repeat (8) begin
         hw_status_i = rand_hw();
         read_word(RB_STATUS, rd);
         check_value("rb_data_o", rd, exp_status_word(hw_status_i, m_good_sync));
      end
      end_test("status word", errs);

      idle_cycles(2);
      $display("%0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- src.f
+incdir+verif
src/radio_ctrl_pkg.sv
src/set_capture.sv
src/misc_ctrl_regs.sv
src/vita_timer.sv
src/status_readback.sv
src/radio_ctrl_top.sv
verif/tb_radio_ctrl.sv

//--- Bender.yml
package:
  name: radio_ctrl

sources:
  - files:
      - src/radio_ctrl_pkg.sv
      - src/set_capture.sv
      - src/misc_ctrl_regs.sv
      - src/vita_timer.sv
      - src/status_readback.sv
      - src/radio_ctrl_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_radio_ctrl.sv
